//--- glb_bank.sv
`timescale 1ns/10ps

module glb_bank (
    input  logic                clk,
    input  logic                clk_en,

    // write port
    input  logic                wr_en,
    input  glb_pkg::bank_addr_t wr_addr,
    input  glb_pkg::glb_data_t  wr_data,

    // read port, one cycle latency
    input  logic                rd_en,
    input  glb_pkg::bank_addr_t rd_addr,
    output glb_pkg::glb_data_t  rd_data
);
    import glb_pkg::*;

    glb_data_t mem [BANK_DEPTH];

    // read first
    // same edge read and write to one word returns the old word
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (rd_en) begin
                rd_data <= mem[rd_addr];
            end
            if (wr_en) begin
                mem[wr_addr] <= wr_data;
            end
        end
    end

    // the owner decode in the core must hand over clean addresses
    a_wr_addr_known : assert property (
        @(posedge clk)
        (clk_en && wr_en) |-> !$isunknown(wr_addr)
    );

    a_rd_addr_known : assert property (
        @(posedge clk)
        (clk_en && rd_en) |-> !$isunknown(rd_addr)
    );

endmodule

//--- glb_pkg.sv
package glb_pkg;

    // ring geometry
    localparam int NUM_TILES = 4;
    localparam int TILE_SEL_ADDR_WIDTH = 2;

    // word address inside one bank
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

    // global word address, tile select on top of bank word
    localparam int GLB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH;

    localparam int DATA_WIDTH = 32;

    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;
    typedef logic [BANK_ADDR_WIDTH-1:0]     bank_addr_t;
    typedef logic [GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [DATA_WIDTH-1:0]          glb_data_t;

    // one ring slot
    // all zero means the slot is empty
    typedef struct packed {
        // request bits
        logic      wr_en;
        logic      rd_en;
        // set by the owning core once rd_data holds the bank word
        logic      rd_valid;
        glb_addr_t addr;
        glb_data_t wr_data;
        glb_data_t rd_data;
    } packet_t;

endpackage

//--- glb_ring_top.sv
`timescale 1ns/10ps

module glb_ring_top (
    input  logic               clk,
    input  logic               clk_en,
    input  logic               reset,

    // host request
    input  logic               host_wr_en,
    input  logic               host_rd_en,
    input  glb_pkg::glb_addr_t host_addr,
    input  glb_pkg::glb_data_t host_wr_data,

    // retired packets, single cycle strobe
    output logic               result_valid,
    output logic               result_rd_valid,
    output glb_pkg::glb_addr_t result_addr,
    output glb_pkg::glb_data_t result_rd_data
);
    import glb_pkg::*;

    // per tile link wires
    packet_t   wsti [NUM_TILES];
    packet_t   wsto [NUM_TILES];
    packet_t   esti [NUM_TILES];
    packet_t   esto [NUM_TILES];

    // per tile host and result wires
    logic      t_host_wr_en    [NUM_TILES];
    logic      t_host_rd_en    [NUM_TILES];
    glb_addr_t t_host_addr     [NUM_TILES];
    glb_data_t t_host_wr_data  [NUM_TILES];
    logic      t_result_valid  [NUM_TILES];
    logic      t_result_rd_valid [NUM_TILES];
    glb_addr_t t_result_addr   [NUM_TILES];
    glb_data_t t_result_rd_data [NUM_TILES];

    genvar i;
    generate
        for (i = 0; i < NUM_TILES; i++) begin : g_tile
            // west input, unused on the start tile
            if (i == 0) begin : g_west_edge
                assign wsti[i] = '0;
            end else begin : g_west_link
                assign wsti[i] = esto[i-1];
            end

            // east input, unused on the end tile
            if (i == NUM_TILES - 1) begin : g_east_edge
                assign esti[i] = '0;
            end else begin : g_east_link
                assign esti[i] = wsto[i+1];
            end

            // only the head sees host traffic
            assign t_host_wr_en[i]   = (i == 0) ? host_wr_en : 1'b0;
            assign t_host_rd_en[i]   = (i == 0) ? host_rd_en : 1'b0;
            assign t_host_addr[i]    = (i == 0) ? host_addr : '0;
            assign t_host_wr_data[i] = (i == 0) ? host_wr_data : '0;

            glb_tile u_tile (
                .clk               (clk),
                .clk_en            (clk_en),
                .reset             (reset),
                .glb_tile_id       (tile_id_t'(i)),
                .cfg_tile_is_start (i == 0),
                .cfg_tile_is_end   (i == NUM_TILES - 1),
                .packet_wsti       (wsti[i]),
                .packet_wsto       (wsto[i]),
                .packet_esti       (esti[i]),
                .packet_esto       (esto[i]),
                .host_wr_en        (t_host_wr_en[i]),
                .host_rd_en        (t_host_rd_en[i]),
                .host_addr         (t_host_addr[i]),
                .host_wr_data      (t_host_wr_data[i]),
                .result_valid      (t_result_valid[i]),
                .result_rd_valid   (t_result_rd_valid[i]),
                .result_addr       (t_result_addr[i]),
                .result_rd_data    (t_result_rd_data[i])
            );
        end
    endgenerate

    // results leave through the head
    assign result_valid    = t_result_valid[0];
    assign result_rd_valid = t_result_rd_valid[0];
    assign result_addr     = t_result_addr[0];
    assign result_rd_data  = t_result_rd_data[0];

endmodule

//--- glb_tile.sv
`timescale 1ns/10ps

module glb_tile (
    input  logic               clk,
    input  logic               clk_en,
    input  logic               reset,
    input  glb_pkg::tile_id_t  glb_tile_id,
    input  logic               cfg_tile_is_start,
    input  logic               cfg_tile_is_end,

    // ring links
    input  glb_pkg::packet_t   packet_wsti,
    output glb_pkg::packet_t   packet_wsto,
    input  glb_pkg::packet_t   packet_esti,
    output glb_pkg::packet_t   packet_esto,

    // host side
    input  logic               host_wr_en,
    input  logic               host_rd_en,
    input  glb_pkg::glb_addr_t host_addr,
    input  glb_pkg::glb_data_t host_wr_data,

    // result side
    output logic               result_valid,
    output logic               result_rd_valid,
    output glb_pkg::glb_addr_t result_addr,
    output glb_pkg::glb_data_t result_rd_data
);
    import glb_pkg::*;

    // core to router and back
    packet_t packet_c2r;
    packet_t packet_r2c;

    glb_tile_strm_router u_router (
        .clk               (clk),
        .clk_en            (clk_en),
        .reset             (reset),
        .glb_tile_id       (glb_tile_id),
        .packet_wsti       (packet_wsti),
        .packet_wsto       (packet_wsto),
        .packet_esti       (packet_esti),
        .packet_esto       (packet_esto),
        .packet_c2r        (packet_c2r),
        .packet_r2c        (packet_r2c),
        .cfg_tile_is_start (cfg_tile_is_start),
        .cfg_tile_is_end   (cfg_tile_is_end)
    );

    glb_tile_core u_core (
        .clk             (clk),
        .clk_en          (clk_en),
        .reset           (reset),
        .glb_tile_id     (glb_tile_id),
        .packet_r2c      (packet_r2c),
        .packet_c2r      (packet_c2r),
        .host_wr_en      (host_wr_en),
        .host_rd_en      (host_rd_en),
        .host_addr       (host_addr),
        .host_wr_data    (host_wr_data),
        .result_valid    (result_valid),
        .result_rd_valid (result_rd_valid),
        .result_addr     (result_addr),
        .result_rd_data  (result_rd_data)
    );

endmodule

//--- glb_tile_core.sv
`timescale 1ns/10ps

module glb_tile_core (
    input  logic                clk,
    input  logic                clk_en,
    input  logic                reset,
    input  glb_pkg::tile_id_t   glb_tile_id,

    // router side
    input  glb_pkg::packet_t    packet_r2c,
    output glb_pkg::packet_t    packet_c2r,

    // host request, only live on the head tile
    input  logic                host_wr_en,
    input  logic                host_rd_en,
    input  glb_pkg::glb_addr_t  host_addr,
    input  glb_pkg::glb_data_t  host_wr_data,

    // retired packet, only live on the head tile
    output logic                result_valid,
    output logic                result_rd_valid,
    output glb_pkg::glb_addr_t  result_addr,
    output glb_pkg::glb_data_t  result_rd_data
);
    import glb_pkg::*;

    logic       is_head;
    logic       host_req;
    packet_t    host_pkt;
    packet_t    src_pkt;
    tile_id_t   owner_id;
    bank_addr_t word_addr;
    logic       owned;
    logic       bank_wr_en;
    logic       bank_rd_en;
    glb_data_t  bank_rd_data;
    packet_t    pkt_q;
    logic       fill_rd_q;
    logic       retire_valid;

    // tile 0 is the ring head
    assign is_head  = (glb_tile_id == '0);
    assign host_req = host_wr_en | host_rd_en;

    // host strobes into a fresh packet, empty slot when idle
    always_comb begin
        host_pkt = '0;
        if (host_req) begin
            host_pkt.wr_en   = host_wr_en;
            host_pkt.rd_en   = host_rd_en;
            host_pkt.addr    = host_addr;
            host_pkt.wr_data = host_wr_data;
        end
    end

    // head injects, everyone else works on what the router hands in
    assign src_pkt = is_head ? host_pkt : packet_r2c;

    // owner decode from the upper address bits
    assign owner_id  = src_pkt.addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];
    assign word_addr = src_pkt.addr[BANK_ADDR_WIDTH-1:0];
    assign owned     = (owner_id == glb_tile_id);

    assign bank_wr_en = owned & src_pkt.wr_en;
    assign bank_rd_en = owned & src_pkt.rd_en;

    glb_bank u_bank (
        .clk     (clk),
        .clk_en  (clk_en),
        .wr_en   (bank_wr_en),
        .wr_addr (word_addr),
        .wr_data (src_pkt.wr_data),
        .rd_en   (bank_rd_en),
        .rd_addr (word_addr),
        .rd_data (bank_rd_data)
    );

    // outgoing packet stage
    // bank read data lands on the same edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_q     <= '0;
            fill_rd_q <= 1'b0;
        end else if (clk_en) begin
            pkt_q     <= src_pkt;
            fill_rd_q <= bank_rd_en;
        end
    end

    // merge read data into the registered packet
    always_comb begin
        packet_c2r = pkt_q;
        if (fill_rd_q) begin
            packet_c2r.rd_data  = bank_rd_data;
            packet_c2r.rd_valid = 1'b1;
        end
    end

    // retire at the head, any returning non-empty slot
    assign retire_valid = is_head & (packet_r2c.wr_en | packet_r2c.rd_en);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid    <= 1'b0;
            result_rd_valid <= 1'b0;
        end else if (clk_en) begin
            result_valid    <= retire_valid;
            result_rd_valid <= retire_valid & packet_r2c.rd_valid;
        end
    end

    // result payload, only loaded on a retire
    always_ff @(posedge clk) begin
        if (clk_en && retire_valid) begin
            result_addr    <= packet_r2c.addr;
            result_rd_data <= packet_r2c.rd_data;
        end
    end

    // host traffic is wired to tile 0 only
    a_host_only_head : assert property (
        @(posedge clk) disable iff (reset)
        !is_head |-> !(host_wr_en || host_rd_en)
    );

    // a read that made the full loop must have met its owner
    a_read_filled : assert property (
        @(posedge clk) disable iff (reset)
        (is_head && packet_r2c.rd_en) |-> packet_r2c.rd_valid
    );

endmodule

//--- glb_tile_strm_router.sv
`timescale 1ns/10ps

module glb_tile_strm_router (
    input  logic              clk,
    input  logic              clk_en,
    input  logic              reset,
    input  glb_pkg::tile_id_t glb_tile_id,

    // neighbour links
    input  glb_pkg::packet_t  packet_wsti,
    output glb_pkg::packet_t  packet_wsto,
    input  glb_pkg::packet_t  packet_esti,
    output glb_pkg::packet_t  packet_esto,

    // core side
    input  glb_pkg::packet_t  packet_c2r,
    output glb_pkg::packet_t  packet_r2c,

    // ring end flags, tied at the top
    input  logic              cfg_tile_is_start,
    input  logic              cfg_tile_is_end
);
    import glb_pkg::*;

    packet_t c2r_q;
    packet_t west_in;
    packet_t east_in;
    packet_t west_out;
    packet_t east_out;
    logic    tile_even;

    // even tiles work on the eastbound stream, odd tiles on the westbound one
    assign tile_even = ~glb_tile_id[0];

    // turnaround at the ring ends
    // start tile loops its own west output back in
    assign west_in = cfg_tile_is_start ? west_out : packet_wsti;
    // end tile loops its own east output back in
    assign east_in = cfg_tile_is_end ? east_out : packet_esti;

    // core packet pipeline stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c2r_q <= '0;
        end else if (clk_en) begin
            c2r_q <= packet_c2r;
        end
    end

    // switch
    // the core's own direction is fed from c2r_q, the other passes through
    assign packet_r2c = tile_even ? west_in : east_in;
    assign east_out   = tile_even ? c2r_q : west_in;
    assign west_out   = tile_even ? east_in : c2r_q;

    assign packet_wsto = west_out;
    assign packet_esto = east_out;

    // both flags would tie the two turnarounds into a loop
    a_start_end_excl : assert property (
        @(posedge clk) disable iff (reset)
        !(cfg_tile_is_start && cfg_tile_is_end)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the ring testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_glb_ring \
    -Mdir "$BUILD_DIR" -o tb_glb_ring
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_glb_ring" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

exit 0

//--- sources.f
glb_pkg.sv
glb_bank.sv
glb_tile_strm_router.sv
glb_tile_core.sv
glb_tile.sv
glb_ring_top.sv
tb_glb_ring.sv

//--- tb_glb_ring.sv
`timescale 1ns/10ps

module tb_glb_ring;
    import glb_pkg::*;

    localparam int NUM_DIRECTED = 14;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_ENTRIES  = NUM_DIRECTED + NUM_RANDOM;
    // enabled edges from acceptance to result strobe
    localparam int RING_LATENCY = 9;
    // up to 4 cycles per entry plus the drain
    localparam int TIMEOUT_CYCLES = (NUM_ENTRIES + 9) * 4;
    localparam int GLB_DEPTH = 1 << GLB_ADDR_WIDTH;

    // one stimulus row
    typedef struct {
        string     name;
        logic      wr_en;
        logic      rd_en;
        glb_addr_t addr;
        glb_data_t wr_data;
        // cycles with clk_en low after injection
        int        stall;
        // idle enabled cycles after that
        int        gap;
        // expected result from the reference model
        logic      exp_rd_valid;
        glb_data_t exp_rd_data;
    } entry_t;

    // one outstanding result
    typedef struct {
        string     name;
        logic      rd_valid;
        glb_addr_t addr;
        glb_data_t rd_data;
        int        done_edge;
    } expect_t;

    logic      clk;
    logic      clk_en;
    logic      reset;
    logic      host_wr_en;
    logic      host_rd_en;
    glb_addr_t host_addr;
    glb_data_t host_wr_data;
    logic      result_valid;
    logic      result_rd_valid;
    glb_addr_t result_addr;
    glb_data_t result_rd_data;

    entry_t    stim [NUM_ENTRIES];
    expect_t   exp_q [$];
    expect_t   got;
    // reference memory, read first
    glb_data_t model_mem [GLB_DEPTH];
    // words written so far while the table is built
    logic      model_init [GLB_DEPTH];
    int        n_built = 0;

    int   mismatch_count = 0;
    int   missing_count = 0;
    int   unexpected_count = 0;
    int   en_edges = 0;
    int   cycle_count = 0;
    logic last_edge_en = 1'b0;

    glb_ring_top dut (
        .clk             (clk),
        .clk_en          (clk_en),
        .reset           (reset),
        .host_wr_en      (host_wr_en),
        .host_rd_en      (host_rd_en),
        .host_addr       (host_addr),
        .host_wr_data    (host_wr_data),
        .result_valid    (result_valid),
        .result_rd_valid (result_rd_valid),
        .result_addr     (result_addr),
        .result_rd_data  (result_rd_data)
    );

    always #5 clk = ~clk;

    // count enabled edges
    always @(posedge clk) begin
        last_edge_en <= clk_en;
        if (clk_en) begin
            en_edges <= en_edges + 1;
        end
    end

    task automatic check_data(input string name, input glb_data_t exp, input glb_data_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s rd_data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input glb_addr_t exp, input glb_addr_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s addr expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s flag expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            mismatch_count++;
            $display("mismatch %s retire edge expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d missing results, %0d unexpected results",
                 mismatch_count, missing_count, unexpected_count);
    endtask

    task automatic drive_idle(input logic en);
        clk_en       = en;
        host_wr_en   = 1'b0;
        host_rd_en   = 1'b0;
        host_addr    = '0;
        host_wr_data = '0;
    endtask

    task automatic add_entry(input string name, input logic wr, input logic rd,
                             input glb_addr_t addr, input glb_data_t data,
                             input int stall, input int gap);
        stim[n_built].name    = name;
        stim[n_built].wr_en   = wr;
        stim[n_built].rd_en   = rd;
        stim[n_built].addr    = addr;
        stim[n_built].wr_data = data;
        stim[n_built].stall   = stall;
        stim[n_built].gap     = gap;
        // old word goes out before the write lands
        stim[n_built].exp_rd_valid = rd;
        stim[n_built].exp_rd_data  = model_mem[addr];
        if (wr) begin
            model_mem[addr]  = data;
            model_init[addr] = 1'b1;
        end
        n_built++;
    endtask

    task automatic build_table();
        glb_addr_t addr;
        glb_data_t data;
        int        op;
        int        stall;
        foreach (model_init[i]) begin
            model_init[i] = 1'b0;
        end
        // one word in each tile's range
        add_entry("wr_t0", 1'b1, 1'b0, 8'h05, 32'h0a0a_0005, 0, 3);
        add_entry("wr_t1", 1'b1, 1'b0, 8'h47, 32'h1b1b_0047, 0, 3);
        add_entry("wr_t2", 1'b1, 1'b0, 8'h8a, 32'h2c2c_008a, 0, 3);
        add_entry("wr_t3", 1'b1, 1'b0, 8'hfc, 32'h3d3d_00fc, 0, 3);
        add_entry("rd_t0", 1'b0, 1'b1, 8'h05, 32'h0, 0, 3);
        add_entry("rd_t1", 1'b0, 1'b1, 8'h47, 32'h0, 0, 3);
        add_entry("rd_t2", 1'b0, 1'b1, 8'h8a, 32'h0, 0, 3);
        add_entry("rd_t3", 1'b0, 1'b1, 8'hfc, 32'h0, 0, 3);
        // read and write together return the old word
        add_entry("rw_old_t1", 1'b1, 1'b1, 8'h47, 32'h5e5e_1147, 0, 3);
        add_entry("rd_new_t1", 1'b0, 1'b1, 8'h47, 32'h0, 0, 3);
        // clk_en held low mid-flight
        add_entry("wr_stall_t2", 1'b1, 1'b0, 8'h90, 32'h7777_0090, 3, 0);
        add_entry("rd_stall_t2", 1'b0, 1'b1, 8'h90, 32'h0, 3, 0);
        add_entry("rw_stall_t3", 1'b1, 1'b1, 8'hfc, 32'h9999_00fc, 2, 1);
        add_entry("rd_b2b_t3", 1'b0, 1'b1, 8'hfc, 32'h0, 0, 0);
        // random tail on a small word range per tile so reads hit written words
        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr  = glb_addr_t'($urandom_range(0, 3) * 64 + $urandom_range(0, 7));
            data  = glb_data_t'($urandom);
            // op 0 writes, op 1 reads and op 2 does both
            op    = model_init[addr] ? int'($urandom_range(0, 2)) : 0;
            stall = ($urandom_range(0, 7) == 0) ? 2 : 0;
            add_entry($sformatf("rand_%0d", i), op != 1, op != 0, addr, data, stall, 0);
        end
    endtask

    task automatic apply_entry(input entry_t e);
        expect_t x;
        @(negedge clk);
        clk_en       = 1'b1;
        host_wr_en   = e.wr_en;
        host_rd_en   = e.rd_en;
        host_addr    = e.addr;
        host_wr_data = e.wr_data;
        // the next edge accepts the packet as enabled edge en_edges + 1
        x.name      = e.name;
        x.rd_valid  = e.exp_rd_valid;
        x.addr      = e.addr;
        x.rd_data   = e.exp_rd_data;
        x.done_edge = en_edges + RING_LATENCY;
        exp_q.push_back(x);
        repeat (e.stall) begin
            @(negedge clk);
            drive_idle(1'b0);
        end
        repeat (e.gap) begin
            @(negedge clk);
            drive_idle(1'b1);
        end
    endtask

    // result monitor looks only after an enabled edge
    always @(negedge clk) begin
        if (!reset && last_edge_en && result_valid) begin
            if (exp_q.size() == 0) begin
                unexpected_count++;
                $display("result for address %h arrived with no packet outstanding",
                         result_addr);
            end else begin
                got = exp_q.pop_front();
                check_addr(got.name, got.addr, result_addr);
                check_flag(got.name, got.rd_valid, result_rd_valid);
                if (got.rd_valid) begin
                    check_data(got.name, got.rd_data, result_rd_data);
                end
                check_latency(got.name, got.done_edge, en_edges);
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles, %0d expected results never arrived",
                         cycle_count, exp_q.size());
                missing_count = missing_count + exp_q.size();
                print_counts();
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        drive_idle(1'b1);
        void'($urandom(93092));
        build_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        // nothing may retire before the first packet
        repeat (3) begin
            @(negedge clk);
            check_flag("idle_after_reset", 1'b0, result_valid);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(stim[i]);
        end
        @(negedge clk);
        drive_idle(1'b1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // catch stray results
        repeat (12) @(negedge clk);
        print_counts();
        if (mismatch_count + missing_count + unexpected_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
